// File: common/dtlb_pkg.sv
package dtlb_pkg;

  // set index comes from the low page bits
  localparam int SET_BITS  = 4;
  localparam int NUM_SETS  = 1 << SET_BITS;
  localparam int VPN_W     = 20;
  localparam int TAG_W     = VPN_W - SET_BITS;
  localparam int ASID_W    = 8;
  localparam int PPN_W     = 16;
  // wide enough for up to 8 ways
  localparam int WAY_IDX_W = 3;

  typedef struct packed {
    logic read;
    logic write;
    logic exec;
  } dtlb_perm_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [ASID_W-1:0] asid;
    logic [PPN_W-1:0]  ppn;
    dtlb_perm_t        perm;
  } dtlb_entry_t;

  typedef struct packed {
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
  } dtlb_lookup_t;

  typedef struct packed {
    logic                 hit;
    logic [WAY_IDX_W-1:0] way;
    logic [PPN_W-1:0]     ppn;
    dtlb_perm_t           perm;
  } dtlb_result_t;

  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_FILL  = 2'd1,
    OP_INVAL = 2'd2
  } dtlb_op_e;

  typedef struct packed {
    dtlb_op_e          op;
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
    logic [PPN_W-1:0]  ppn;
    dtlb_perm_t        perm;
  } dtlb_cmd_t;

endpackage

// File: dtlb/dtlb_entry_ram.sv
`timescale 1ns/1ps

module dtlb_entry_ram import dtlb_pkg::*; #(
  parameter int NUM_PORTS = 4
) (
  input  logic                                 clk,
  input  logic [NUM_PORTS-1:0][SET_BITS-1:0]   rd_idx,
  output dtlb_entry_t [NUM_PORTS-1:0]          rd_entry,
  input  logic [SET_BITS-1:0]                  wr_idx,
  input  dtlb_entry_t                          wr_entry,
  input  logic                                 wr_en
);

  dtlb_entry_t mem [NUM_SETS];

  // reads are combinational so lookups finish in the same cycle
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_rd
    assign rd_entry[p] = mem[rd_idx[p]];
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_entry;
    end
  end

endmodule

// File: dtlb/dtlb_way.sv
`timescale 1ns/1ps

module dtlb_way import dtlb_pkg::*; #(
  parameter int NUM_PORTS = 4,
  parameter int NUM_WAYS  = 8,
  parameter int WAY_ID    = 0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          init,
  input  logic [SET_BITS-1:0]           sweep_idx,
  input  dtlb_lookup_t [NUM_PORTS-1:0]  lookup,
  output logic [NUM_PORTS-1:0]          hit,
  output dtlb_entry_t [NUM_PORTS-1:0]   entry,
  input  logic [SET_BITS-1:0]           wr_idx,
  input  logic [TAG_W-1:0]              wr_tag,
  input  logic [ASID_W-1:0]             wr_asid,
  input  logic [PPN_W-1:0]              wr_ppn,
  input  dtlb_perm_t                    wr_perm,
  input  logic                          wr_en,
  input  logic                          wr_valid,
  input  logic [SET_BITS-1:0]           rank_idx,
  output logic [WAY_IDX_W-1:0]          rank,
  input  logic [WAY_IDX_W-1:0]          used_rank,
  input  logic                          rank_en,
  input  logic                          is_used
);

  localparam logic [WAY_IDX_W-1:0] TOP_RANK  = WAY_IDX_W'(NUM_WAYS - 1);
  localparam logic [WAY_IDX_W-1:0] INIT_RANK = WAY_IDX_W'(WAY_ID);

  logic [NUM_PORTS-1:0][SET_BITS-1:0] rd_idx;
  dtlb_entry_t                        ram_wr_entry;
  logic [SET_BITS-1:0]                ram_wr_idx;
  logic                               ram_wr_en;
  logic [WAY_IDX_W-1:0]               rank_mem [NUM_SETS];

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    assign rd_idx[p] = lookup[p].vpn[SET_BITS-1:0];
    assign hit[p] = entry[p].valid &&
                    entry[p].tag == lookup[p].vpn[VPN_W-1:SET_BITS] &&
                    entry[p].asid == lookup[p].asid;
  end

  // sweep writes a cleared entry, otherwise the command data
  always_comb begin
    ram_wr_entry = '0;
    ram_wr_idx   = sweep_idx;
    if (!init) begin
      ram_wr_entry.valid = wr_valid;
      ram_wr_entry.tag   = wr_tag;
      ram_wr_entry.asid  = wr_asid;
      ram_wr_entry.ppn   = wr_ppn;
      ram_wr_entry.perm  = wr_perm;
      ram_wr_idx         = wr_idx;
    end
  end

  // storage stays untouched while reset is held
  assign ram_wr_en = !rst && (init || wr_en);

  dtlb_entry_ram #(
    .NUM_PORTS (NUM_PORTS)
  ) u_ram (
    .clk      (clk),
    .rd_idx   (rd_idx),
    .rd_entry (entry),
    .wr_idx   (ram_wr_idx),
    .wr_entry (ram_wr_entry),
    .wr_en    (ram_wr_en)
  );

  assign rank = rank_mem[rank_idx];

  // used way drops to 0, ways ranked below it move up by one
  always_ff @(posedge clk) begin
    if (!rst) begin
      if (init) begin
        rank_mem[sweep_idx] <= INIT_RANK;
      end else if (rank_en) begin
        if (is_used) begin
          rank_mem[rank_idx] <= '0;
        end else if (rank < used_rank && rank != TOP_RANK) begin
          rank_mem[rank_idx] <= rank + 1'b1;
        end
      end
    end
  end

endmodule

// File: dtlb/dtlb.sv
`timescale 1ns/1ps

module dtlb import dtlb_pkg::*; #(
  parameter int NUM_PORTS = 4,
  parameter int NUM_WAYS  = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          init,
  input  logic [SET_BITS-1:0]           sweep_idx,
  input  dtlb_lookup_t [NUM_PORTS-1:0]  lookup,
  output dtlb_result_t [NUM_PORTS-1:0]  result,
  input  logic                          touch,
  input  dtlb_cmd_t                     cmd
);

  // the ways get one extra compare port for the command
  localparam int LK_PORTS = NUM_PORTS + 1;
  localparam int CMD_PORT = NUM_PORTS;
  localparam logic [WAY_IDX_W-1:0] TOP_RANK = WAY_IDX_W'(NUM_WAYS - 1);

  dtlb_lookup_t [LK_PORTS-1:0]                way_lookup;
  logic [NUM_WAYS-1:0][LK_PORTS-1:0]          way_hit;
  dtlb_entry_t [NUM_WAYS-1:0][LK_PORTS-1:0]   way_entry;
  logic [NUM_WAYS-1:0][WAY_IDX_W-1:0]         way_rank;

  logic                  is_fill;
  logic                  is_inval;
  logic [SET_BITS-1:0]   rank_idx;
  logic [NUM_WAYS-1:0]   cmd_hit;
  logic [NUM_WAYS-1:0]   victim;
  logic [NUM_WAYS-1:0]   fill_sel;
  logic [NUM_WAYS-1:0]   wr_sel;
  logic [NUM_WAYS-1:0]   touch_sel;
  logic [NUM_WAYS-1:0]   used_sel;
  logic [WAY_IDX_W-1:0]  used_rank;
  logic                  rank_en;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lk
    assign way_lookup[p] = lookup[p];
  end
  assign way_lookup[CMD_PORT].vpn  = cmd.vpn;
  assign way_lookup[CMD_PORT].asid = cmd.asid;

  assign is_fill  = cmd.op == OP_FILL;
  assign is_inval = cmd.op == OP_INVAL;

  // rank port follows the command set, else port 0's set
  assign rank_idx = (cmd.op != OP_NONE) ? cmd.vpn[SET_BITS-1:0]
                                        : lookup[0].vpn[SET_BITS-1:0];

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_sel
    assign cmd_hit[w]   = way_hit[w][CMD_PORT];
    assign victim[w]    = way_rank[w] == TOP_RANK;
    assign touch_sel[w] = way_hit[w][0] && touch && !init;
  end

  // fill goes to the matching way, else the lru victim
  assign fill_sel = (|cmd_hit) ? cmd_hit : victim;
  assign wr_sel   = ({NUM_WAYS{is_fill}} & fill_sel) | ({NUM_WAYS{is_inval}} & cmd_hit);

  always_comb begin
    used_sel = '0;
    if (is_fill) begin
      used_sel = fill_sel;
    end else if (cmd.op == OP_NONE) begin
      used_sel = touch_sel;
    end
  end

  assign rank_en = |used_sel;

  always_comb begin
    used_rank = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      used_rank = used_rank | ({WAY_IDX_W{used_sel[w]}} & way_rank[w]);
    end
  end

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    dtlb_way #(
      .NUM_PORTS (LK_PORTS),
      .NUM_WAYS  (NUM_WAYS),
      .WAY_ID    (w)
    ) u_way (
      .clk       (clk),
      .rst       (rst),
      .init      (init),
      .sweep_idx (sweep_idx),
      .lookup    (way_lookup),
      .hit       (way_hit[w]),
      .entry     (way_entry[w]),
      .wr_idx    (cmd.vpn[SET_BITS-1:0]),
      .wr_tag    (cmd.vpn[VPN_W-1:SET_BITS]),
      .wr_asid   (cmd.asid),
      .wr_ppn    (cmd.ppn),
      .wr_perm   (cmd.perm),
      .wr_en     (wr_sel[w]),
      .wr_valid  (is_fill),
      .rank_idx  (rank_idx),
      .rank      (way_rank[w]),
      .used_rank (used_rank),
      .rank_en   (rank_en),
      .is_used   (used_sel[w])
    );
  end

  // one-hot merge, at most one way hits per port
  always_comb begin
    result = '0;
    if (!init) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          result[p].hit  = result[p].hit | way_hit[w][p];
          result[p].way  = result[p].way |
                           ({WAY_IDX_W{way_hit[w][p]}} & WAY_IDX_W'(w));
          result[p].ppn  = result[p].ppn |
                           ({PPN_W{way_hit[w][p]}} & way_entry[w][p].ppn);
          result[p].perm = result[p].perm |
                           ({$bits(dtlb_perm_t){way_hit[w][p]}} & way_entry[w][p].perm);
        end
      end
    end
  end

endmodule

// File: hw/dtlb_init_ctrl.sv
`timescale 1ns/1ps

module dtlb_init_ctrl import dtlb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  output logic                 init,
  output logic [SET_BITS-1:0]  sweep_idx,
  output logic                 ready
);

  typedef enum logic {
    ST_SWEEP,
    ST_RUN
  } state_e;

  state_e              state;
  logic [SET_BITS-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_SWEEP;
      cnt   <= '0;
    end else begin
      case (state)
        ST_SWEEP: begin
          cnt <= cnt + 1'b1;
          // last set cleared this cycle
          if (&cnt) begin
            state <= ST_RUN;
          end
        end
        default: begin
          state <= ST_RUN;
        end
      endcase
    end
  end

  assign init      = state == ST_SWEEP;
  assign ready     = state == ST_RUN;
  assign sweep_idx = cnt;

endmodule

// File: hw/dtlb_top.sv
`timescale 1ns/1ps

module dtlb_top import dtlb_pkg::*; #(
  parameter int NUM_PORTS = 4,
  parameter int NUM_WAYS  = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  dtlb_lookup_t [NUM_PORTS-1:0]  lookup,
  input  logic                          touch,
  input  dtlb_cmd_t                     cmd,
  output dtlb_result_t [NUM_PORTS-1:0]  result,
  output logic                          ready
);

  logic                init;
  logic [SET_BITS-1:0] sweep_idx;
  dtlb_cmd_t           cmd_gated;

  // commands before the sweep ends are dropped
  always_comb begin
    cmd_gated = cmd;
    if (!ready) begin
      cmd_gated.op = OP_NONE;
    end
  end

  dtlb_init_ctrl u_init_ctrl (
    .clk       (clk),
    .rst       (rst),
    .init      (init),
    .sweep_idx (sweep_idx),
    .ready     (ready)
  );

  dtlb #(
    .NUM_PORTS (NUM_PORTS),
    .NUM_WAYS  (NUM_WAYS)
  ) u_dtlb (
    .clk       (clk),
    .rst       (rst),
    .init      (init),
    .sweep_idx (sweep_idx),
    .lookup    (lookup),
    .result    (result),
    .touch     (touch),
    .cmd       (cmd_gated)
  );

endmodule

// File: sim/dtlb_checker.sv
`timescale 1ns/1ps

module dtlb_checker import dtlb_pkg::*; #(
  parameter int NUM_PORTS = 4,
  parameter int NUM_WAYS  = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  dtlb_lookup_t [NUM_PORTS-1:0]  lookup,
  input  logic                          touch,
  input  dtlb_cmd_t                     cmd,
  input  dtlb_result_t [NUM_PORTS-1:0]  result,
  input  logic                          ready,
  input  int                            test_id,
  input  logic                          test_end,
  input  logic                          run_end,
  output int                            errors
);

  // model of every set
  logic              m_valid [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0]  m_tag   [NUM_SETS][NUM_WAYS];
  logic [ASID_W-1:0] m_asid  [NUM_SETS][NUM_WAYS];
  logic [PPN_W-1:0]  m_ppn   [NUM_SETS][NUM_WAYS];
  dtlb_perm_t        m_perm  [NUM_SETS][NUM_WAYS];
  int                m_rank  [NUM_SETS][NUM_WAYS];

  int   since_rst;
  logic exp_ready;
  int   test_checks;
  int   test_errs;
  int   total_checks;
  int   tests_run;
  int   tests_failed;
  int   s;
  int   w;

  function automatic int find_way(input logic [VPN_W-1:0] vpn, input logic [ASID_W-1:0] asid);
    int set;
    set = int'(vpn[SET_BITS-1:0]);
    for (int k = 0; k < NUM_WAYS; k++) begin
      if (m_valid[set][k] && m_tag[set][k] == vpn[VPN_W-1:SET_BITS] && m_asid[set][k] == asid) begin
        return k;
      end
    end
    return -1;
  endfunction

  function automatic int lru_way(input int set);
    for (int k = 0; k < NUM_WAYS; k++) begin
      if (m_rank[set][k] == NUM_WAYS - 1) begin
        return k;
      end
    end
    return 0;
  endfunction

  // used way goes to 0, lower ranks move up one
  function automatic void use_way(input int set, input int way);
    int r;
    r = m_rank[set][way];
    for (int k = 0; k < NUM_WAYS; k++) begin
      if (m_rank[set][k] < r) begin
        m_rank[set][k] = m_rank[set][k] + 1;
      end
    end
    m_rank[set][way] = 0;
  endfunction

  task automatic check_port(input int p);
    int           hw;
    int           set;
    dtlb_result_t exp;
    string        msg;
    exp = '0;
    hw  = find_way(lookup[p].vpn, lookup[p].asid);
    set = int'(lookup[p].vpn[SET_BITS-1:0]);
    if (exp_ready && hw >= 0) begin
      exp.hit  = 1'b1;
      exp.way  = WAY_IDX_W'(hw);
      exp.ppn  = m_ppn[set][hw];
      exp.perm = m_perm[set][hw];
    end
    test_checks++;
    if (result[p] !== exp) begin
      test_errs++;
      msg = $sformatf("port %0d vpn %h asid %h expected hit %0b way %0d ppn %h perm %b",
                      p, lookup[p].vpn, lookup[p].asid, exp.hit, exp.way, exp.ppn, exp.perm);
      msg = {msg, $sformatf(", got hit %0b way %0d ppn %h perm %b",
                            result[p].hit, result[p].way, result[p].ppn, result[p].perm)};
      $display("** Error at %0t: %s", $time, msg);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      since_rst = 0;
      exp_ready = 1'b0;
      for (int i = 0; i < NUM_SETS; i++) begin
        for (int k = 0; k < NUM_WAYS; k++) begin
          m_valid[i][k] = 1'b0;
          m_rank[i][k]  = k;
        end
      end
      test_checks  = 0;
      test_errs    = 0;
      total_checks = 0;
      tests_run    = 0;
      tests_failed = 0;
      errors       = 0;
    end else begin
      // sweep takes 16 cycles after reset
      exp_ready = since_rst >= 16;
      test_checks++;
      if (ready !== exp_ready) begin
        test_errs++;
        $display("** Error at %0t: ready is %b, %0d cycles after reset", $time, ready, since_rst);
      end
      since_rst++;
      for (int p = 0; p < NUM_PORTS; p++) begin
        check_port(p);
      end
      if (exp_ready && cmd.op == OP_FILL) begin
        s = int'(cmd.vpn[SET_BITS-1:0]);
        w = find_way(cmd.vpn, cmd.asid);
        if (w < 0) begin
          w = lru_way(s);
        end
        m_valid[s][w] = 1'b1;
        m_tag[s][w]   = cmd.vpn[VPN_W-1:SET_BITS];
        m_asid[s][w]  = cmd.asid;
        m_ppn[s][w]   = cmd.ppn;
        m_perm[s][w]  = cmd.perm;
        use_way(s, w);
      end else if (exp_ready && cmd.op == OP_INVAL) begin
        s = int'(cmd.vpn[SET_BITS-1:0]);
        w = find_way(cmd.vpn, cmd.asid);
        if (w >= 0) begin
          m_valid[s][w] = 1'b0;
        end
      end else if (exp_ready && touch) begin
        w = find_way(lookup[0].vpn, lookup[0].asid);
        if (w >= 0) begin
          use_way(int'(lookup[0].vpn[SET_BITS-1:0]), w);
        end
      end
    end
    if (test_end) begin
      tests_run++;
      if (test_errs > 0) begin
        tests_failed++;
      end
      $display("test %0d %s: %0d checks, %0d errors", test_id,
               test_errs == 0 ? "ok" : "failed", test_checks, test_errs);
      total_checks += test_checks;
      errors       += test_errs;
      test_checks   = 0;
      test_errs     = 0;
    end
    if (run_end) begin
      errors += test_errs;
      $display("tests %0d run, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, total_checks + test_checks, errors);
    end
  end

endmodule

// File: sim/tb_dtlb.sv
`timescale 1ns/1ps

module tb_dtlb import dtlb_pkg::*; ();

  localparam int NUM_PORTS = 4;
  localparam int NUM_WAYS  = 8;
  localparam int TIMEOUT   = 100;

  logic                         clk;
  logic                         rst;
  dtlb_lookup_t [NUM_PORTS-1:0] lookup;
  logic                         touch;
  dtlb_cmd_t                    cmd;
  dtlb_result_t [NUM_PORTS-1:0] result;
  logic                         ready;
  int                           test_id;
  logic                         test_end;
  logic                         run_end;
  int                           err_total;
  logic [VPN_W-1:0]             vpns [$];
  logic [ASID_W-1:0]            asids [$];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  dtlb_top #(
    .NUM_PORTS (NUM_PORTS),
    .NUM_WAYS  (NUM_WAYS)
  ) dut_i (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookup),
    .touch  (touch),
    .cmd    (cmd),
    .result (result),
    .ready  (ready)
  );

  dtlb_checker #(
    .NUM_PORTS (NUM_PORTS),
    .NUM_WAYS  (NUM_WAYS)
  ) u_checker (
    .clk      (clk),
    .rst      (rst),
    .lookup   (lookup),
    .touch    (touch),
    .cmd      (cmd),
    .result   (result),
    .ready    (ready),
    .test_id  (test_id),
    .test_end (test_end),
    .run_end  (run_end),
    .errors   (err_total)
  );

  // mostly known pages, pct_known percent of the time
  task automatic random_lookups(input int pct_known);
    int k;
    @(negedge clk);
    cmd.op = OP_NONE;
    touch  = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (vpns.size() > 0 && int'($urandom_range(99)) < pct_known) begin
        k = int'($urandom_range(vpns.size() - 1));
        lookup[p].vpn  = vpns[k];
        lookup[p].asid = asids[k];
      end else begin
        lookup[p].vpn  = VPN_W'($urandom);
        lookup[p].asid = ASID_W'($urandom);
      end
    end
  endtask

  task automatic issue(input dtlb_op_e op, input logic [VPN_W-1:0] vpn,
                       input logic [ASID_W-1:0] asid);
    @(negedge clk);
    touch     = 1'b0;
    cmd.op    = op;
    cmd.vpn   = vpn;
    cmd.asid  = asid;
    cmd.ppn   = PPN_W'($urandom);
    cmd.perm  = 3'($urandom);
    if (op == OP_FILL) begin
      vpns.push_back(vpn);
      asids.push_back(asid);
    end
  endtask

  task automatic touch_lookup(input logic [VPN_W-1:0] vpn, input logic [ASID_W-1:0] asid);
    @(negedge clk);
    cmd.op         = OP_NONE;
    touch          = 1'b1;
    lookup[0].vpn  = vpn;
    lookup[0].asid = asid;
  endtask

  task automatic end_test();
    @(negedge clk);
    cmd.op   = OP_NONE;
    touch    = 1'b0;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
    test_id++;
  endtask

  // lookups keep running while the sweep is busy
  task automatic wait_ready(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < TIMEOUT && !ok; n++) begin
      random_lookups(50);
      ok = ready;
    end
  endtask

  task automatic run_tests();
    int k;
    repeat (40) random_lookups(50);
    end_test();
    repeat (60) begin
      issue(OP_FILL, {1'b0, 19'($urandom)}, ASID_W'($urandom_range(127)));
      repeat (3) random_lookups(80);
    end
    end_test();
    // wrong asid on port 0, wrong tag on port 1
    for (int i = 0; i < vpns.size(); i++) begin
      @(negedge clk);
      cmd.op         = OP_NONE;
      lookup[0].vpn  = vpns[i];
      lookup[0].asid = asids[i] | 8'h80;
      lookup[1].vpn  = vpns[i] ^ 20'h80000;
      lookup[1].asid = asids[i];
      lookup[2].vpn  = vpns[i];
      lookup[2].asid = asids[i];
    end
    end_test();
    for (int i = 0; i < NUM_WAYS + 4; i++) begin
      issue(OP_FILL, {16'hA000 + 16'(i), 4'h5}, 8'h03);
      k = vpns.size() - 1 - int'($urandom_range(3));
      touch_lookup(vpns[k], asids[k]);
      repeat (2) random_lookups(100);
    end
    repeat (30) random_lookups(100);
    end_test();
    repeat (8) begin
      k = int'($urandom_range(vpns.size() - 1));
      issue(OP_FILL, vpns[k], asids[k]);
      repeat (3) random_lookups(100);
    end
    end_test();
    repeat (10) begin
      k = vpns.size() - 1 - int'($urandom_range(NUM_WAYS + 3));
      issue(OP_INVAL, vpns[k], asids[k]);
      @(negedge clk);
      cmd.op = OP_NONE;
      for (int p = 0; p < NUM_PORTS; p++) begin
        lookup[p].vpn  = vpns[k];
        lookup[p].asid = asids[k];
      end
      repeat (3) random_lookups(100);
    end
    end_test();
  endtask

  initial begin
    bit ok;
    void'($urandom(659));
    rst      = 1'b1;
    touch    = 1'b0;
    cmd      = '0;
    lookup   = '0;
    test_id  = 1;
    test_end = 1'b0;
    run_end  = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    // dropped by the top while the sweep runs
    issue(OP_FILL, 20'h01234, 8'h11);
    wait_ready(ok);
    if (!ok) begin
      $display("timeout: ready did not rise after reset");
      $display("Simulation FAILED");
      $finish;
    end else begin
      run_tests();
      @(negedge clk);
      run_end = 1'b1;
      @(negedge clk);
      run_end = 1'b0;
      if (err_total == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

// File: vlog.f
common/dtlb_pkg.sv
dtlb/dtlb_entry_ram.sv
dtlb/dtlb_way.sv
dtlb/dtlb.sv
hw/dtlb_init_ctrl.sv
hw/dtlb_top.sv
sim/dtlb_checker.sv
sim/tb_dtlb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the DTLB testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_dtlb -o tb_dtlb
./obj_dir/tb_dtlb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
exit 0
